/* source/alu_pkg.sv */
//##########################################################################
// Shared widths, latencies and opcodes for the integer execution cluster.
// Every module and interface of the cluster imports what it needs from
// here, and the testbench uses the same definitions for its model.
//##########################################################################

`default_nettype none

package alu_pkg;

    // Operand and result width
    localparam int data_width = 32;

    // Destination register tag width
    localparam int dest_width = 5;

    // Shift amounts come from the low bits of operand b
    localparam int shift_width = $clog2(data_width);

    // Cycles from acceptance to the multiplier result
    localparam int mul_latency = 3;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_slt  = 4'd7,
        op_mul  = 4'd8,
        op_mulh = 4'd9
    } alu_opcode_t;

endpackage

`default_nettype wire

/* source/alu_streams.sv */
//##########################################################################
// Stream interfaces inside the execution cluster.
// The issue interface carries one operation from the dispatcher to a unit,
// the result interface carries one result from a unit to the combiner.
// Neither has a ready, units never stall and valid lasts one cycle.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

interface alu_issue_if;
    import alu_pkg::*;

    logic valid;
    alu_opcode_t opcode;
    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [dest_width-1:0] dest;

    modport sender (output valid, opcode, operand_a, operand_b, dest);
    modport receiver (input valid, opcode, operand_a, operand_b, dest);

endinterface

interface alu_result_if;
    import alu_pkg::*;

    logic valid;
    logic [data_width-1:0] data;
    logic [dest_width-1:0] dest;

    modport sender (output valid, data, dest);
    modport receiver (input valid, data, dest);

endinterface

`default_nettype wire

/* source/alu_dispatcher.sv */
//##########################################################################
// Routes issued operations to the simple unit or to the multiplier.
// Routing is combinational, so a unit sees its valid in the accept cycle.
// issue_ready drops only for a simple operation that would finish in the
// same cycle as a multiply accepted earlier.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_dispatcher (
    input logic clock,
    input logic reset,
    input logic issue_valid,
    input alu_pkg::alu_opcode_t issue_opcode,
    input logic [alu_pkg::data_width-1:0] issue_operand_a,
    input logic [alu_pkg::data_width-1:0] issue_operand_b,
    input logic [alu_pkg::dest_width-1:0] issue_dest,
    output logic issue_ready,
    alu_issue_if.sender simple_issue,
    alu_issue_if.sender mul_issue
);
    import alu_pkg::*;

    logic is_mul;
    logic accept;
    logic mul_accept;

    // Bit i is set when a multiply was accepted i cycles ago, bit 0 being
    // the acceptance in the current cycle
    logic [mul_latency-1:1] mul_age;

    assign is_mul = (issue_opcode == op_mul) || (issue_opcode == op_mulh);

    // The simple unit takes one cycle, so a multiply accepted
    // mul_latency-1 cycles ago would land on the same edge
    assign issue_ready = is_mul || !mul_age[mul_latency-1];

    assign accept = issue_valid && issue_ready;
    assign mul_accept = accept && is_mul;

    always_ff @(posedge clock) begin
        if (reset) begin
            mul_age <= '0;
        end else begin
            mul_age <= {mul_age[mul_latency-2:1], mul_accept};
        end
    end

    assign simple_issue.valid = accept && !is_mul;
    assign mul_issue.valid = mul_accept;

    // Payload fields go to both units, only the valid tells them apart
    assign simple_issue.opcode = issue_opcode;
    assign simple_issue.operand_a = issue_operand_a;
    assign simple_issue.operand_b = issue_operand_b;
    assign simple_issue.dest = issue_dest;

    assign mul_issue.opcode = issue_opcode;
    assign mul_issue.operand_a = issue_operand_a;
    assign mul_issue.operand_b = issue_operand_b;
    assign mul_issue.dest = issue_dest;

endmodule

`default_nettype wire

/* source/alu_simple_unit.sv */
//##########################################################################
// Single cycle unit for add, subtract, logic, shifts and signed compare.
// The result is registered and appears on the result interface one
// cycle after the operation is issued.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_simple_unit (
    input logic clock,
    input logic reset,
    alu_issue_if.receiver issue,
    alu_result_if.sender result
);
    import alu_pkg::*;

    logic [data_width-1:0] computed;
    logic [shift_width-1:0] shift_amount;
    logic less_than;

    assign shift_amount = issue.operand_b[shift_width-1:0];
    assign less_than = $signed(issue.operand_a) < $signed(issue.operand_b);

    always_comb begin
        case (issue.opcode)
            op_add: computed = issue.operand_a + issue.operand_b;
            op_sub: computed = issue.operand_a - issue.operand_b;
            op_and: computed = issue.operand_a & issue.operand_b;
            op_or: computed = issue.operand_a | issue.operand_b;
            op_xor: computed = issue.operand_a ^ issue.operand_b;
            op_sll: computed = issue.operand_a << shift_amount;
            op_srl: computed = issue.operand_a >> shift_amount;
            op_slt: computed = {{(data_width-1){1'b0}}, less_than};
            // Multiplies never reach this unit
            default: computed = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            result.data <= computed;
            result.dest <= issue.dest;
        end
    end

endmodule

`default_nettype wire

/* source/alu_multiplier.sv */
//##########################################################################
// Three stage pipelined signed multiplier.
// Stage one captures the operands, stage two forms the full product and
// stage three picks the low or high half. One operation per cycle is
// accepted, so up to three can be in flight.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_multiplier (
    input logic clock,
    input logic reset,
    alu_issue_if.receiver issue,
    alu_result_if.sender result
);
    import alu_pkg::*;

    // One valid bit per stage
    logic [mul_latency-1:0] stage_valid;

    logic signed [data_width-1:0] s1_a;
    logic signed [data_width-1:0] s1_b;
    logic [dest_width-1:0] s1_dest;
    logic s1_high;

    logic signed [2*data_width-1:0] s2_product;
    logic [dest_width-1:0] s2_dest;
    logic s2_high;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[mul_latency-2:0], issue.valid};
        end
    end

    assign result.valid = stage_valid[mul_latency-1];

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            s1_a <= issue.operand_a;
            s1_b <= issue.operand_b;
            s1_dest <= issue.dest;
            s1_high <= (issue.opcode == op_mulh);
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid[0]) begin
            s2_product <= s1_a * s1_b;
            s2_dest <= s1_dest;
            s2_high <= s1_high;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid[1]) begin
            if (s2_high) begin
                result.data <= s2_product[2*data_width-1:data_width];
            end else begin
                result.data <= s2_product[data_width-1:0];
            end
            result.dest <= s2_dest;
        end
    end

endmodule

`default_nettype wire

/* source/alu_results_combiner.sv */
//##########################################################################
// Merges the simple unit and multiplier results into one registered
// write-back stream with a zero flag. The dispatcher keeps the two
// sources from being valid together; the multiplier wins if they are.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_results_combiner (
    input logic clock,
    input logic reset,
    alu_result_if.receiver simple_result,
    alu_result_if.receiver mul_result,
    output logic result_valid,
    output logic [alu_pkg::data_width-1:0] result_data,
    output logic [alu_pkg::dest_width-1:0] result_dest,
    output logic result_zero
);
    import alu_pkg::*;

    logic selected_valid;
    logic [data_width-1:0] selected_data;
    logic [dest_width-1:0] selected_dest;

    assign selected_valid = mul_result.valid || simple_result.valid;
    assign selected_data = mul_result.valid ? mul_result.data : simple_result.data;
    assign selected_dest = mul_result.valid ? mul_result.dest : simple_result.dest;

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= selected_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (selected_valid) begin
            result_data <= selected_data;
            result_dest <= selected_dest;
            result_zero <= (selected_data == '0);
        end
    end

endmodule

`default_nettype wire

/* source/alu_core.sv */
//##########################################################################
// Top level of the integer execution cluster.
// Operations enter through a valid and ready handshake and leave as a
// valid only write-back stream. Simple operations return two cycles after
// acceptance and multiplies four, possibly out of order, matched by tag.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input logic clock,
    input logic reset,
    input logic issue_valid,
    input alu_pkg::alu_opcode_t issue_opcode,
    input logic [alu_pkg::data_width-1:0] issue_operand_a,
    input logic [alu_pkg::data_width-1:0] issue_operand_b,
    input logic [alu_pkg::dest_width-1:0] issue_dest,
    output logic issue_ready,
    output logic result_valid,
    output logic [alu_pkg::data_width-1:0] result_data,
    output logic [alu_pkg::dest_width-1:0] result_dest,
    output logic result_zero
);

    alu_issue_if simple_issue_bus ();
    alu_issue_if mul_issue_bus ();
    alu_result_if simple_result_bus ();
    alu_result_if mul_result_bus ();

    alu_dispatcher dispatcher_inst (
        .clock(clock),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_opcode(issue_opcode),
        .issue_operand_a(issue_operand_a),
        .issue_operand_b(issue_operand_b),
        .issue_dest(issue_dest),
        .issue_ready(issue_ready),
        .simple_issue(simple_issue_bus.sender),
        .mul_issue(mul_issue_bus.sender)
    );

    alu_simple_unit simple_unit_inst (
        .clock(clock),
        .reset(reset),
        .issue(simple_issue_bus.receiver),
        .result(simple_result_bus.sender)
    );

    alu_multiplier multiplier_inst (
        .clock(clock),
        .reset(reset),
        .issue(mul_issue_bus.receiver),
        .result(mul_result_bus.sender)
    );

    alu_results_combiner combiner_inst (
        .clock(clock),
        .reset(reset),
        .simple_result(simple_result_bus.receiver),
        .mul_result(mul_result_bus.receiver),
        .result_valid(result_valid),
        .result_data(result_data),
        .result_dest(result_dest),
        .result_zero(result_zero)
    );

endmodule

`default_nettype wire

/* test/alu_model.svh */
//##########################################################################
// Reference model and scoreboard for the execution cluster testbench.
// Included inside the testbench module after the package import, so the
// functions see the opcode enum and the widths directly.
//##########################################################################

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Scoreboard indexed by destination tag
logic pending [0:(1<<dest_width)-1];
logic [data_width-1:0] exp_data [0:(1<<dest_width)-1];
logic exp_zero [0:(1<<dest_width)-1];
int due_cycle [0:(1<<dest_width)-1];
int outstanding;

function automatic logic opcode_is_mul(alu_opcode_t opcode);
    return (opcode == op_mul) || (opcode == op_mulh);
endfunction

function automatic logic [data_width-1:0] model_result(
    alu_opcode_t opcode,
    logic [data_width-1:0] a,
    logic [data_width-1:0] b
);
    logic signed [2*data_width-1:0] product;
    logic [4:0] amount;
    // Sign extend both operands by hand so the full product fits in 64 bits
    product = $signed({{data_width{a[data_width-1]}}, a})
            * $signed({{data_width{b[data_width-1]}}, b});
    amount = b[4:0];
    case (opcode)
        op_add: return a + b;
        op_sub: return a - b;
        op_and: return a & b;
        op_or: return a | b;
        op_xor: return a ^ b;
        op_sll: return a << amount;
        op_srl: return a >> amount;
        op_slt: return ($signed(a) < $signed(b)) ? 1 : 0;
        op_mul: return product[data_width-1:0];
        default: return product[2*data_width-1:data_width];
    endcase
endfunction

// True when some pending result already owns the given write-back cycle
function automatic logic due_collides(int due);
    for (int t = 0; t < (1 << dest_width); t++) begin
        if (pending[t] && due_cycle[t] == due) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// Returns a pending tag whose result should already have arrived, or -1
function automatic int overdue_tag(int now);
    for (int t = 0; t < (1 << dest_width); t++) begin
        if (pending[t] && due_cycle[t] <= now) begin
            return t;
        end
    end
    return -1;
endfunction

`endif

/* test/alu_core_tb.sv */
//##########################################################################
// Testbench for the execution cluster top level.
// Issues random operations with random gaps, predicts each result, its
// zero flag and its write-back cycle, and checks issue_ready every cycle.
// Outputs are sampled on the falling edge, inputs change after the rising.
//##########################################################################

`timescale 1ns/1ns
`default_nettype none

module alu_core_tb;
    import alu_pkg::*;

    `include "alu_model.svh"

    localparam int op_count = 400;
    localparam int ready_timeout = 20;
    localparam int drain_timeout = 50;

    logic clock = 1'b0;
    logic reset;
    logic issue_valid;
    alu_opcode_t issue_opcode;
    logic [data_width-1:0] issue_operand_a;
    logic [data_width-1:0] issue_operand_b;
    logic [dest_width-1:0] issue_dest;
    logic issue_ready;
    logic result_valid;
    logic [data_width-1:0] result_data;
    logic [dest_width-1:0] result_dest;
    logic result_zero;

    int cycle_count;
    // Multiply acceptances one and two cycles back
    logic mul_hist1;
    logic mul_hist2;

    alu_core alu_core_inst (
        .clock(clock),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_opcode(issue_opcode),
        .issue_operand_a(issue_operand_a),
        .issue_operand_b(issue_operand_b),
        .issue_dest(issue_dest),
        .issue_ready(issue_ready),
        .result_valid(result_valid),
        .result_data(result_data),
        .result_dest(result_dest),
        .result_zero(result_zero)
    );

    always #10 clock = ~clock;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped at the first error");
        end
    endtask

    // Records acceptances and retires results, one step per clock cycle
    always @(negedge clock) begin : monitor
        logic expected_ready;
        logic mul_now;
        logic [dest_width-1:0] tag;
        int due;
        int late;
        if (reset) begin
            check_value("result_valid", result_valid, 0);
            mul_hist1 = 1'b0;
            mul_hist2 = 1'b0;
        end else begin
            cycle_count++;
            if (result_valid) begin
                tag = result_dest;
                if (pending[tag] !== 1'b1) begin
                    report_failure($sformatf("A result arrived for tag %0d with nothing pending",
                                             tag));
                end
                check_value("result_data", result_data, exp_data[tag]);
                check_value("result_zero", result_zero, exp_zero[tag]);
                check_value("result cycle", cycle_count, due_cycle[tag]);
                pending[tag] = 1'b0;
                outstanding--;
            end
            late = overdue_tag(cycle_count);
            if (late >= 0) begin
                report_failure($sformatf("No result arrived for tag %0d by cycle %0d",
                                         late, cycle_count));
            end
            expected_ready = opcode_is_mul(issue_opcode) || !mul_hist2;
            check_value("issue_ready", issue_ready, expected_ready);
            mul_now = 1'b0;
            if (issue_valid && issue_ready) begin
                mul_now = opcode_is_mul(issue_opcode);
                due = cycle_count + (mul_now ? 4 : 2);
                if (due_collides(due)) begin
                    report_failure($sformatf("Two results would collide in cycle %0d", due));
                end
                tag = issue_dest;
                exp_data[tag] = model_result(issue_opcode, issue_operand_a, issue_operand_b);
                exp_zero[tag] = (exp_data[tag] == 0);
                due_cycle[tag] = due;
                pending[tag] = 1'b1;
                outstanding++;
            end
            mul_hist2 = mul_hist1;
            mul_hist1 = mul_now;
        end
    end

    task automatic pick_free_tag(output logic [dest_width-1:0] tag);
        int start;
        logic found;
        start = $urandom_range(0, (1 << dest_width) - 1);
        found = 1'b0;
        for (int i = 0; i < (1 << dest_width); i++) begin
            if (!found && !pending[(start + i) % (1 << dest_width)]) begin
                tag = (start + i) % (1 << dest_width);
                found = 1'b1;
            end
        end
        if (!found) begin
            report_failure("Every destination tag is still in flight");
        end
    endtask

    // Starts just after a rising edge and returns just after the accepting edge
    task automatic issue_operation(input alu_opcode_t opcode, input logic [data_width-1:0] a,
                                   input logic [data_width-1:0] b,
                                   input logic [dest_width-1:0] tag);
        logic accepted;
        int waited;
        issue_valid = 1'b1;
        issue_opcode = opcode;
        issue_operand_a = a;
        issue_operand_b = b;
        issue_dest = tag;
        accepted = 1'b0;
        waited = 0;
        while (!accepted) begin
            @(negedge clock);
            if (issue_ready) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited > ready_timeout) begin
                    report_failure("Timed out waiting for issue_ready");
                end
            end
        end
        @(posedge clock);
        #1;
        issue_valid = 1'b0;
    endtask

    initial begin : stimulus
        alu_opcode_t opcode;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [dest_width-1:0] tag;
        int waited;
        void'($urandom(60));
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_opcode = op_add;
        issue_operand_a = '0;
        issue_operand_b = '0;
        issue_dest = '0;
        cycle_count = 0;
        outstanding = 0;
        for (int t = 0; t < (1 << dest_width); t++) begin
            pending[t] = 1'b0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int n = 0; n < op_count; n++) begin
            // Roughly one in three operations goes to the multiplier
            if ($urandom_range(0, 99) < 30) begin
                opcode = ($urandom_range(0, 1) == 0) ? op_mul : op_mulh;
            end else begin
                opcode = alu_opcode_t'($urandom_range(0, 7));
            end
            a = $urandom;
            b = $urandom;
            if ($urandom_range(0, 15) == 0) begin
                a = '0;
            end
            if ($urandom_range(0, 7) == 0) begin
                b = a;
            end
            pick_free_tag(tag);
            issue_operation(opcode, a, b, tag);
            if ($urandom_range(0, 1) == 0) begin
                repeat ($urandom_range(1, 3)) begin
                    @(posedge clock);
                    #1;
                end
            end
        end

        waited = 0;
        while (outstanding != 0) begin
            @(posedge clock);
            waited++;
            if (waited > drain_timeout) begin
                report_failure("Timed out waiting for the remaining results");
            end
        end
        // A few idle cycles so a stray write-back would still be caught
        repeat (5) @(posedge clock);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
source/alu_pkg.sv
source/alu_streams.sv
source/alu_dispatcher.sv
source/alu_simple_unit.sv
source/alu_multiplier.sv
source/alu_results_combiner.sv
source/alu_core.sv
test/alu_core_tb.sv

/* Bender.yml */
package:
  name: alu_core

sources:
  - files:
      - source/alu_pkg.sv
      - source/alu_streams.sv
      - source/alu_dispatcher.sv
      - source/alu_simple_unit.sv
      - source/alu_multiplier.sv
      - source/alu_results_combiner.sv
      - source/alu_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/alu_core_tb.sv
